// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    // instruction fields
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // primary opcodes
    localparam opcodeT opR     = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opBle   = 6'h06;
    localparam opcodeT opBgt   = 6'h07;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // function codes under opR
    localparam functT fnJr  = 6'h08;
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnSlt = 6'h2a;

    // pc source mux
    typedef logic [1:0] pcSrcT;
    localparam pcSrcT pcFromAlu    = 2'd0;
    localparam pcSrcT pcFromAluOut = 2'd1;
    localparam pcSrcT pcFromJump   = 2'd2;
    localparam pcSrcT pcFromVector = 2'd3;

    // register file write address
    typedef logic [1:0] regDstT;
    localparam regDstT dstRt = 2'd0;
    localparam regDstT dstRd = 2'd1;
    localparam regDstT dstRa = 2'd2;

    // register file write data
    typedef logic [1:0] wbSrcT;
    localparam wbSrcT wbAluOut   = 2'd0;
    localparam wbSrcT wbMem      = 2'd1;
    localparam wbSrcT wbLessThan = 2'd2;

    // alu second operand
    typedef logic [1:0] aluSrcBT;
    localparam aluSrcBT srcBReg       = 2'd0;
    localparam aluSrcBT srcBFour      = 2'd1;
    localparam aluSrcBT srcBImm       = 2'd2;
    localparam aluSrcBT srcBBranchOff = 2'd3;

    // alu function
    typedef logic [2:0] aluOpT;
    localparam aluOpT aluPassA = 3'd0;
    localparam aluOpT aluAdd   = 3'd1;
    localparam aluOpT aluSub   = 3'd2;
    localparam aluOpT aluAnd   = 3'd3;
    localparam aluOpT aluLess  = 3'd7;

    // branch condition, evaluated by the datapath
    typedef logic [1:0] branchOpT;
    localparam branchOpT brEq = 2'd0;
    localparam branchOpT brNe = 2'd1;
    localparam branchOpT brGt = 2'd2;
    localparam branchOpT brLe = 2'd3;

    // exception cause
    typedef logic [1:0] causeT;
    localparam causeT causeNone     = 2'd0;
    localparam causeT causeUndef    = 2'd1;
    localparam causeT causeOverflow = 2'd2;

    typedef enum logic [4:0] {
        clsAdd, clsSub, clsAnd, clsSlt, clsJr,
        clsAddi, clsAddiu, clsSlti,
        clsBeq, clsBne, clsBle, clsBgt,
        clsLw, clsSw,
        clsJ, clsJal,
        clsUndef
    } instrClassT;

    typedef enum logic [4:0] {
        stFetch1, stFetch2, stFetch3,
        stDecode1, stDecode2,
        stAluExec, stAluWb,
        stImmExec, stImmWb,
        stBrCompare, stBrTake,
        stMemAddr, stLwRead, stLwWb, stSwWrite,
        stJump, stJalLink, stJr,
        stExcRecord, stExcVector,
        stRetire
    } stepT;

endpackage

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::opcodeT     opcode,
    input  ctrlPkg::functT      funct,
    output ctrlPkg::instrClassT instrClass
);
    import ctrlPkg::*;

    always_comb begin
        instrClass = clsUndef;
        case (opcode)
            opR: begin
                // funct only matters for register-register ops
                case (funct)
                    fnAdd: instrClass = clsAdd;
                    fnSub: instrClass = clsSub;
                    fnAnd: instrClass = clsAnd;
                    fnSlt: instrClass = clsSlt;
                    fnJr: instrClass = clsJr;
                    default: instrClass = clsUndef;
                endcase
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opAddiu: begin
                instrClass = clsAddiu;
            end
            opSlti: begin
                instrClass = clsSlti;
            end
            opBeq: begin
                instrClass = clsBeq;
            end
            opBne: begin
                instrClass = clsBne;
            end
            opBle: begin
                instrClass = clsBle;
            end
            opBgt: begin
                instrClass = clsBgt;
            end
            opLw: begin
                instrClass = clsLw;
            end
            opSw: begin
                instrClass = clsSw;
            end
            opJ: begin
                instrClass = clsJ;
            end
            opJal: begin
                instrClass = clsJal;
            end
            // everything else traps as undefined
            default: begin
                instrClass = clsUndef;
            end
        endcase
    end

endmodule

// ==== logic/stepSequencer.sv ====
`timescale 1ns/1ps

module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::instrClassT instrClass,
    input  logic                overflow,
    output ctrlPkg::stepT       step,
    output ctrlPkg::instrClassT latchedClass,
    output ctrlPkg::causeT      cause
);
    import ctrlPkg::*;

    stepT nextStep;
    logic ovfTrap;

    // only signed adds and subtracts trap on overflow
    always_comb begin
        ovfTrap = 1'b0;
        if (step == stAluExec) begin
            ovfTrap = overflow && (latchedClass == clsAdd || latchedClass == clsSub);
        end else if (step == stImmExec) begin
            ovfTrap = overflow && (latchedClass == clsAddi);
        end
    end

    always_comb begin
        nextStep = stRetire;
        case (step)
            stFetch1: nextStep = stFetch2;
            stFetch2: nextStep = stFetch3;
            stFetch3: nextStep = stDecode1;
            stDecode1: nextStep = stDecode2;
            stDecode2: begin
                // dispatch on the freshly decoded class
                case (instrClass)
                    clsAdd, clsSub, clsAnd, clsSlt: nextStep = stAluExec;
                    clsAddi, clsAddiu, clsSlti: nextStep = stImmExec;
                    clsBeq, clsBne, clsBle, clsBgt: nextStep = stBrCompare;
                    clsLw, clsSw: nextStep = stMemAddr;
                    clsJ: nextStep = stJump;
                    clsJr: nextStep = stJr;
                    clsJal: nextStep = stJalLink;
                    default: nextStep = stExcRecord;
                endcase
            end
            stAluExec: begin
                nextStep = ovfTrap ? stExcRecord : stAluWb;
            end
            stImmExec: begin
                nextStep = ovfTrap ? stExcRecord : stImmWb;
            end
            stBrCompare: nextStep = stBrTake;
            stMemAddr: begin
                nextStep = (latchedClass == clsLw) ? stLwRead : stSwWrite;
            end
            stLwRead: nextStep = stLwWb;
            // link first, then share the plain jump step
            stJalLink: nextStep = stJump;
            stExcRecord: nextStep = stExcVector;
            stRetire: nextStep = stFetch1;
            // single-step tails all retire
            default: nextStep = stRetire;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= stFetch1;
        end else begin
            step <= nextStep;
        end
    end

    // class is captured once per instruction and steers the execute steps
    always_ff @(posedge clk) begin
        if (reset) begin
            latchedClass <= clsUndef;
        end else if (step == stDecode2) begin
            latchedClass <= instrClass;
        end
    end

    // decode stage can only trap on undef, execute stages only on overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            cause <= causeNone;
        end else if (nextStep == stExcRecord) begin
            cause <= (step == stDecode2) ? causeUndef : causeOverflow;
        end
    end

endmodule

// ==== logic/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen (
    input  ctrlPkg::stepT       step,
    input  ctrlPkg::instrClassT latchedClass,
    output logic                pcWrite,
    output logic                pcWriteCond,
    output logic                iOrD,
    output logic                memWrite,
    output logic                irWrite,
    output logic                aWrite,
    output logic                bWrite,
    output logic                regWrite,
    output logic                aluSrcA,
    output logic                aluOutWrite,
    output logic                extendSigned,
    output logic                epcWrite,
    output logic                causeWrite,
    output ctrlPkg::pcSrcT      pcSource,
    output ctrlPkg::regDstT     regDst,
    output ctrlPkg::wbSrcT      memToReg,
    output ctrlPkg::aluSrcBT    aluSrcB,
    output ctrlPkg::aluOpT      aluOp,
    output ctrlPkg::branchOpT   branchOp
);
    import ctrlPkg::*;

    always_comb begin
        // idle word, also what stRetire drives
        pcWrite = 1'b0;
        pcWriteCond = 1'b0;
        iOrD = 1'b0;
        memWrite = 1'b0;
        irWrite = 1'b0;
        aWrite = 1'b0;
        bWrite = 1'b0;
        regWrite = 1'b0;
        aluSrcA = 1'b0;
        aluOutWrite = 1'b0;
        extendSigned = 1'b0;
        epcWrite = 1'b0;
        causeWrite = 1'b0;
        pcSource = pcFromAlu;
        regDst = dstRt;
        memToReg = wbAluOut;
        aluSrcB = srcBReg;
        aluOp = aluPassA;
        branchOp = brEq;

        case (step)
            stFetch1: begin
                // pc + 4 into aluOut
                aluSrcB = srcBFour;
                aluOp = aluAdd;
                aluOutWrite = 1'b1;
            end
            stFetch2: begin
                pcWrite = 1'b1;
                pcSource = pcFromAluOut;
            end
            stFetch3: begin
                irWrite = 1'b1;
            end
            stDecode1: begin
                // speculative branch target
                aluSrcB = srcBBranchOff;
                aluOp = aluAdd;
                aluOutWrite = 1'b1;
            end
            stDecode2: begin
                aWrite = 1'b1;
                bWrite = 1'b1;
            end
            stAluExec: begin
                aluSrcA = 1'b1;
                aluOutWrite = 1'b1;
                case (latchedClass)
                    clsSub: aluOp = aluSub;
                    clsAnd: aluOp = aluAnd;
                    clsSlt: aluOp = aluLess;
                    default: aluOp = aluAdd;
                endcase
            end
            stAluWb: begin
                regWrite = 1'b1;
                regDst = dstRd;
                memToReg = (latchedClass == clsSlt) ? wbLessThan : wbAluOut;
            end
            stImmExec: begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;
                aluOutWrite = 1'b1;
                aluOp = (latchedClass == clsSlti) ? aluLess : aluAdd;
                // addiu takes its immediate zero-extended
                extendSigned = (latchedClass != clsAddiu);
            end
            stImmWb: begin
                regWrite = 1'b1;
                memToReg = (latchedClass == clsSlti) ? wbLessThan : wbAluOut;
            end
            stBrCompare: begin
                // datapath keeps the compare flags for the next step
                aluSrcA = 1'b1;
                aluOp = aluSub;
            end
            stBrTake: begin
                aluSrcB = srcBBranchOff;
                aluOp = aluAdd;
                pcWriteCond = 1'b1;
                case (latchedClass)
                    clsBne: branchOp = brNe;
                    clsBgt: branchOp = brGt;
                    clsBle: branchOp = brLe;
                    default: branchOp = brEq;
                endcase
            end
            stMemAddr: begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImm;
                aluOp = aluAdd;
                aluOutWrite = 1'b1;
                extendSigned = 1'b1;
            end
            stLwRead: begin
                iOrD = 1'b1;
            end
            stLwWb: begin
                regWrite = 1'b1;
                memToReg = wbMem;
            end
            stSwWrite: begin
                iOrD = 1'b1;
                memWrite = 1'b1;
            end
            stJalLink: begin
                // return address into $ra
                regWrite = 1'b1;
                regDst = dstRa;
            end
            stJump: begin
                pcWrite = 1'b1;
                pcSource = pcFromJump;
            end
            stJr: begin
                // rs passes straight through the alu
                aluSrcA = 1'b1;
                pcWrite = 1'b1;
            end
            stExcRecord: begin
                // epc gets pc - 4, the faulting instruction
                aluSrcB = srcBFour;
                aluOp = aluSub;
                epcWrite = 1'b1;
                causeWrite = 1'b1;
            end
            stExcVector: begin
                pcWrite = 1'b1;
                pcSource = pcFromVector;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic              clk,
    input  logic              reset,
    input  ctrlPkg::opcodeT   opcode,
    input  ctrlPkg::functT    funct,
    input  logic              overflow,
    output ctrlPkg::causeT    cause,
    output logic              pcWrite,
    output logic              pcWriteCond,
    output logic              iOrD,
    output logic              memWrite,
    output logic              irWrite,
    output logic              aWrite,
    output logic              bWrite,
    output logic              regWrite,
    output logic              aluSrcA,
    output logic              aluOutWrite,
    output logic              extendSigned,
    output logic              epcWrite,
    output logic              causeWrite,
    output ctrlPkg::pcSrcT    pcSource,
    output ctrlPkg::regDstT   regDst,
    output ctrlPkg::wbSrcT    memToReg,
    output ctrlPkg::aluSrcBT  aluSrcB,
    output ctrlPkg::aluOpT    aluOp,
    output ctrlPkg::branchOpT branchOp
);
    import ctrlPkg::*;

    instrClassT decodedClass;
    instrClassT latchedClass;
    stepT step;

    instrDecoder i_decoder (
        .opcode(opcode),
        .funct(funct),
        .instrClass(decodedClass)
    );

    stepSequencer i_sequencer (
        .clk(clk),
        .reset(reset),
        .instrClass(decodedClass),
        .overflow(overflow),
        .step(step),
        .latchedClass(latchedClass),
        .cause(cause)
    );

    controlWordGen i_wordGen (
        .step(step),
        .latchedClass(latchedClass),
        .pcWrite(pcWrite),
        .pcWriteCond(pcWriteCond),
        .iOrD(iOrD),
        .memWrite(memWrite),
        .irWrite(irWrite),
        .aWrite(aWrite),
        .bWrite(bWrite),
        .regWrite(regWrite),
        .aluSrcA(aluSrcA),
        .aluOutWrite(aluOutWrite),
        .extendSigned(extendSigned),
        .epcWrite(epcWrite),
        .causeWrite(causeWrite),
        .pcSource(pcSource),
        .regDst(regDst),
        .memToReg(memToReg),
        .aluSrcB(aluSrcB),
        .aluOp(aluOp),
        .branchOp(branchOp)
    );

endmodule

// ==== verif/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;
    import ctrlPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_DIRECTED = 22;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_INSTR = NUM_DIRECTED + NUM_RANDOM;
    // lw is the longest instruction at 9 cycles
    localparam int MAX_CYCLES = 12;

    // one cycle of control outputs, also used as a compare mask
    typedef struct packed {
        causeT    cause;
        logic     pcWrite;
        logic     pcWriteCond;
        logic     iOrD;
        logic     memWrite;
        logic     irWrite;
        logic     aWrite;
        logic     bWrite;
        logic     regWrite;
        logic     aluSrcA;
        logic     aluOutWrite;
        logic     extendSigned;
        logic     epcWrite;
        logic     causeWrite;
        pcSrcT    pcSource;
        regDstT   regDst;
        wbSrcT    memToReg;
        aluSrcBT  aluSrcB;
        aluOpT    aluOp;
        branchOpT branchOp;
    } ctrlWordT;

    logic     clk;
    logic     reset;
    opcodeT   opcode;
    functT    funct;
    logic     overflow;
    causeT    cause;
    logic     pcWrite;
    logic     pcWriteCond;
    logic     iOrD;
    logic     memWrite;
    logic     irWrite;
    logic     aWrite;
    logic     bWrite;
    logic     regWrite;
    logic     aluSrcA;
    logic     aluOutWrite;
    logic     extendSigned;
    logic     epcWrite;
    logic     causeWrite;
    pcSrcT    pcSource;
    regDstT   regDst;
    wbSrcT    memToReg;
    aluSrcBT  aluSrcB;
    aluOpT    aluOp;
    branchOpT branchOp;

    // instruction stream
    opcodeT opList [0:NUM_INSTR-1];
    functT  fnList [0:NUM_INSTR-1];
    logic   ovfList [0:NUM_INSTR-1];
    int     numLoaded = 0;
    int     instrIdx = 0;

    // expected sequence of the current instruction
    ctrlWordT expWord [0:15];
    ctrlWordT expMask [0:15];
    int       expLen = 0;
    causeT    expCause = causeNone;

    int curInstr = -1;
    int curCycle = 0;
    int errCount = 0;
    int failedInstr = 0;

    controlUnit i_dut (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .overflow(overflow),
        .cause(cause),
        .pcWrite(pcWrite),
        .pcWriteCond(pcWriteCond),
        .iOrD(iOrD),
        .memWrite(memWrite),
        .irWrite(irWrite),
        .aWrite(aWrite),
        .bWrite(bWrite),
        .regWrite(regWrite),
        .aluSrcA(aluSrcA),
        .aluOutWrite(aluOutWrite),
        .extendSigned(extendSigned),
        .epcWrite(epcWrite),
        .causeWrite(causeWrite),
        .pcSource(pcSource),
        .regDst(regDst),
        .memToReg(memToReg),
        .aluSrcB(aluSrcB),
        .aluOp(aluOp),
        .branchOp(branchOp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic addInstr(input opcodeT op, input functT fn, input logic ovf);
        opList[numLoaded] = op;
        fnList[numLoaded] = fn;
        ovfList[numLoaded] = ovf;
        numLoaded++;
    endtask

    // strobes, operand A select and cause are checked in every cycle
    function automatic ctrlWordT strobeMask();
        ctrlWordT m;
        m = '0;
        m.cause = '1;
        m.pcWrite = 1'b1;
        m.pcWriteCond = 1'b1;
        m.iOrD = 1'b1;
        m.memWrite = 1'b1;
        m.irWrite = 1'b1;
        m.aWrite = 1'b1;
        m.bWrite = 1'b1;
        m.regWrite = 1'b1;
        m.aluSrcA = 1'b1;
        m.aluOutWrite = 1'b1;
        m.epcWrite = 1'b1;
        m.causeWrite = 1'b1;
        return m;
    endfunction

    // level 0 strobes only, 1 adds the alu fields, 2 checks everything
    function automatic void pushWord(input ctrlWordT w, input int level);
        ctrlWordT m;
        m = strobeMask();
        w.cause = expCause;
        if (level >= 1) begin
            m.aluOp = '1;
            m.aluSrcB = '1;
            m.extendSigned = 1'b1;
        end
        if (w.pcWrite || w.pcWriteCond) begin
            m.pcSource = '1;
        end
        if (w.pcWriteCond) begin
            m.branchOp = '1;
        end
        if (w.regWrite) begin
            m.regDst = '1;
            m.memToReg = '1;
        end
        if (level >= 2) begin
            m = '1;
        end
        expWord[expLen] = w;
        expMask[expLen] = m;
        expLen++;
    endfunction

    // expected control sequence from stFetch1 through stRetire
    function automatic int buildExpected(input opcodeT op, input functT fn, input logic ovf);
        ctrlWordT w;
        logic trap;
        logic undef;
        expLen = 0;
        trap = 1'b0;
        undef = 1'b0;
        // fetch: pc + 4, pc update, instruction register
        w = '0;
        w.aluOutWrite = 1'b1;
        w.aluOp = aluAdd;
        w.aluSrcB = srcBFour;
        pushWord(w, 1);
        w = '0;
        w.pcWrite = 1'b1;
        w.pcSource = pcFromAluOut;
        pushWord(w, 0);
        w = '0;
        w.irWrite = 1'b1;
        pushWord(w, 0);
        // decode: branch target, then operand registers
        w = '0;
        w.aluOutWrite = 1'b1;
        w.aluOp = aluAdd;
        w.aluSrcB = srcBBranchOff;
        pushWord(w, 1);
        w = '0;
        w.aWrite = 1'b1;
        w.bWrite = 1'b1;
        pushWord(w, 0);
        case (op)
            opR: begin
                if (fn == fnJr) begin
                    // rs passes through the alu
                    w = '0;
                    w.aluSrcA = 1'b1;
                    w.pcWrite = 1'b1;
                    w.pcSource = pcFromAlu;
                    pushWord(w, 0);
                end else if (fn == fnAdd || fn == fnSub || fn == fnAnd || fn == fnSlt) begin
                    w = '0;
                    w.aluSrcA = 1'b1;
                    w.aluOutWrite = 1'b1;
                    w.aluSrcB = srcBReg;
                    w.aluOp = (fn == fnSub) ? aluSub :
                              (fn == fnAnd) ? aluAnd :
                              (fn == fnSlt) ? aluLess : aluAdd;
                    pushWord(w, 1);
                    trap = ovf && (fn == fnAdd || fn == fnSub);
                    if (!trap) begin
                        w = '0;
                        w.regWrite = 1'b1;
                        w.regDst = dstRd;
                        w.memToReg = (fn == fnSlt) ? wbLessThan : wbAluOut;
                        pushWord(w, 0);
                    end
                end else begin
                    undef = 1'b1;
                end
            end
            opAddi, opAddiu, opSlti: begin
                w = '0;
                w.aluSrcA = 1'b1;
                w.aluOutWrite = 1'b1;
                w.aluSrcB = srcBImm;
                w.aluOp = (op == opSlti) ? aluLess : aluAdd;
                // only addiu zero-extends
                w.extendSigned = (op != opAddiu);
                pushWord(w, 1);
                trap = ovf && (op == opAddi);
                if (!trap) begin
                    w = '0;
                    w.regWrite = 1'b1;
                    w.regDst = dstRt;
                    w.memToReg = (op == opSlti) ? wbLessThan : wbAluOut;
                    pushWord(w, 0);
                end
            end
            opBeq, opBne, opBle, opBgt: begin
                // compare step reads register A and writes nothing
                w = '0;
                w.aluSrcA = 1'b1;
                pushWord(w, 0);
                w = '0;
                w.pcWriteCond = 1'b1;
                w.pcSource = pcFromAlu;
                case (op)
                    opBne: w.branchOp = brNe;
                    opBle: w.branchOp = brLe;
                    opBgt: w.branchOp = brGt;
                    default: w.branchOp = brEq;
                endcase
                pushWord(w, 0);
            end
            opLw, opSw: begin
                w = '0;
                w.aluSrcA = 1'b1;
                w.aluOutWrite = 1'b1;
                w.aluSrcB = srcBImm;
                w.aluOp = aluAdd;
                w.extendSigned = 1'b1;
                pushWord(w, 1);
                w = '0;
                w.iOrD = 1'b1;
                if (op == opSw) begin
                    w.memWrite = 1'b1;
                    pushWord(w, 0);
                end else begin
                    pushWord(w, 0);
                    w = '0;
                    w.regWrite = 1'b1;
                    w.regDst = dstRt;
                    w.memToReg = wbMem;
                    pushWord(w, 0);
                end
            end
            opJ, opJal: begin
                if (op == opJal) begin
                    // link into $ra before the jump
                    w = '0;
                    w.regWrite = 1'b1;
                    w.regDst = dstRa;
                    w.memToReg = wbAluOut;
                    pushWord(w, 0);
                end
                w = '0;
                w.pcWrite = 1'b1;
                w.pcSource = pcFromJump;
                pushWord(w, 0);
            end
            default: begin
                undef = 1'b1;
            end
        endcase
        if (trap || undef) begin
            expCause = undef ? causeUndef : causeOverflow;
            w = '0;
            w.epcWrite = 1'b1;
            w.causeWrite = 1'b1;
            pushWord(w, 0);
            w = '0;
            w.pcWrite = 1'b1;
            w.pcSource = pcFromVector;
            pushWord(w, 0);
        end
        // retire, every output idle
        w = '0;
        pushWord(w, 2);
        return expLen;
    endfunction

    task automatic checkField(input string name, input logic [7:0] got,
                              input logic [7:0] exp, input logic enable);
        if (enable && got !== exp) begin
            if (curInstr < 0) begin
                $display("Fail %s in reset cycle %0d: expected %h, got %h",
                         name, curCycle, exp, got);
            end else begin
                $display("Fail %s in instr %0d cycle %0d: expected %h, got %h",
                         name, curInstr, curCycle, exp, got);
            end
            errCount++;
        end
    endtask

    task automatic compareCycle(input ctrlWordT e, input ctrlWordT m);
        checkField("cause", 8'(cause), 8'(e.cause), |m.cause);
        checkField("pcWrite", 8'(pcWrite), 8'(e.pcWrite), m.pcWrite);
        checkField("pcWriteCond", 8'(pcWriteCond), 8'(e.pcWriteCond), m.pcWriteCond);
        checkField("iOrD", 8'(iOrD), 8'(e.iOrD), m.iOrD);
        checkField("memWrite", 8'(memWrite), 8'(e.memWrite), m.memWrite);
        checkField("irWrite", 8'(irWrite), 8'(e.irWrite), m.irWrite);
        checkField("aWrite", 8'(aWrite), 8'(e.aWrite), m.aWrite);
        checkField("bWrite", 8'(bWrite), 8'(e.bWrite), m.bWrite);
        checkField("regWrite", 8'(regWrite), 8'(e.regWrite), m.regWrite);
        checkField("aluSrcA", 8'(aluSrcA), 8'(e.aluSrcA), m.aluSrcA);
        checkField("aluOutWrite", 8'(aluOutWrite), 8'(e.aluOutWrite), m.aluOutWrite);
        checkField("extendSigned", 8'(extendSigned), 8'(e.extendSigned), m.extendSigned);
        checkField("epcWrite", 8'(epcWrite), 8'(e.epcWrite), m.epcWrite);
        checkField("causeWrite", 8'(causeWrite), 8'(e.causeWrite), m.causeWrite);
        checkField("pcSource", 8'(pcSource), 8'(e.pcSource), |m.pcSource);
        checkField("regDst", 8'(regDst), 8'(e.regDst), |m.regDst);
        checkField("memToReg", 8'(memToReg), 8'(e.memToReg), |m.memToReg);
        checkField("aluSrcB", 8'(aluSrcB), 8'(e.aluSrcB), |m.aluSrcB);
        checkField("aluOp", 8'(aluOp), 8'(e.aluOp), |m.aluOp);
        checkField("branchOp", 8'(branchOp), 8'(e.branchOp), |m.branchOp);
    endtask

    initial begin : stimulus
        int seed;
        int j;
        int pick;
        int rnd;
        functT rndFn;
        seed = 51;
        rnd = $urandom(seed);
        reset = 1'b1;
        opcode = opR;
        funct = fnAdd;
        overflow = 1'b0;
        // every kept instruction, no overflow
        addInstr(opR, fnAdd, 1'b0);
        addInstr(opR, fnSub, 1'b0);
        addInstr(opR, fnAnd, 1'b0);
        addInstr(opR, fnSlt, 1'b0);
        addInstr(opR, fnJr, 1'b0);
        addInstr(opAddi, 6'h00, 1'b0);
        addInstr(opAddiu, 6'h00, 1'b0);
        addInstr(opSlti, 6'h00, 1'b0);
        addInstr(opBeq, 6'h00, 1'b0);
        addInstr(opBne, 6'h00, 1'b0);
        addInstr(opBle, 6'h00, 1'b0);
        addInstr(opBgt, 6'h00, 1'b0);
        addInstr(opLw, 6'h00, 1'b0);
        addInstr(opSw, 6'h00, 1'b0);
        addInstr(opJ, 6'h00, 1'b0);
        addInstr(opJal, 6'h00, 1'b0);
        // undefined opcode, then undefined funct
        addInstr(6'h3f, 6'h00, 1'b0);
        addInstr(opR, 6'h00, 1'b0);
        // overflow traps on the signed ones only
        addInstr(opR, fnAdd, 1'b1);
        addInstr(opR, fnSub, 1'b1);
        addInstr(opAddi, 6'h00, 1'b1);
        addInstr(opAddiu, 6'h00, 1'b1);
        // random mix of the entries above, funct scrambled outside opR
        for (j = 0; j < NUM_RANDOM; j++) begin
            pick = $urandom % 18;
            rnd = $urandom;
            rndFn = rnd[6:1];
            if (opList[pick] == opR) begin
                rndFn = fnList[pick];
            end
            addInstr(opList[pick], rndFn, rnd[0]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // fields change in stFetch2, after the previous instruction is done
        forever begin
            @(posedge clk);
            #1;
            opcode = opList[instrIdx];
            funct = fnList[instrIdx];
            overflow = ovfList[instrIdx];
        end
    end

    initial begin : compare
        int k;
        int c;
        int len;
        int errBefore;
        ctrlWordT idleMask;
        // fetch1 drives aluOutWrite even under reset
        idleMask = strobeMask();
        idleMask.aluOutWrite = 1'b0;
        @(negedge clk);
        while (reset) begin
            compareCycle('0, idleMask);
            curCycle++;
            @(negedge clk);
        end
        $display("reset: %0d cycles checked, %0d errors", curCycle, errCount);
        for (k = 0; k < NUM_INSTR; k++) begin
            curInstr = k;
            instrIdx = k;
            errBefore = errCount;
            len = buildExpected(opList[k], fnList[k], ovfList[k]);
            for (c = 0; c < len; c++) begin
                curCycle = c;
                compareCycle(expWord[c], expMask[c]);
                @(negedge clk);
            end
            if (errCount == errBefore) begin
                $display("instr %0d opcode %h funct %h overflow %b: %0d cycles, ok",
                         k, opList[k], fnList[k], ovfList[k], len);
            end else begin
                $display("instr %0d opcode %h funct %h overflow %b: %0d cycles, mismatch",
                         k, opList[k], fnList[k], ovfList[k], len);
                failedInstr++;
            end
        end
        $display("%0d instructions, %0d passed, %0d failed, %0d mismatches",
                 NUM_INSTR, NUM_INSTR - failedInstr, failedInstr, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((NUM_INSTR * MAX_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles",
                 NUM_INSTR * MAX_CYCLES + RESET_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== ctrlUnit.f ====
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/stepSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
verif/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: ctrlUnit

sources:
  - logic/ctrlPkg.sv
  - logic/instrDecoder.sv
  - logic/stepSequencer.sv
  - logic/controlWordGen.sv
  - logic/controlUnit.sv
  - target: test
    files:
      - verif/controlUnitTb.sv
